// File: logic/fetch_pkg.sv
// Fetch front end shared definitions: widths, queue sizing and opcode classes
`default_nettype none

package fetch_pkg;

  // --------------------------------------------------------------------------
  // datapath widths
  // --------------------------------------------------------------------------
  // address and pc width
  localparam int unsigned XLEN = 32;
  // instruction word width, uncompressed only
  localparam int unsigned ILEN = 32;

  // sequential fetch step in bytes
  localparam int unsigned INSTR_BYTES = 4;
  // low pc bits that stay zero for word aligned fetch
  localparam int unsigned BOOT_ALIGN_BITS = 2;

  // --------------------------------------------------------------------------
  // instruction queue
  // --------------------------------------------------------------------------
  // number of entries, power of two so the pointers wrap naturally
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  // occupancy counter needs one more bit to tell full from empty
  localparam int unsigned QUEUE_CNT_W = QUEUE_PTR_W + 1;

  // --------------------------------------------------------------------------
  // predecode
  // --------------------------------------------------------------------------
  // major opcode field, bits 6..0 of the word
  localparam int unsigned OPCODE_W = 7;
  localparam logic [OPCODE_W-1:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [OPCODE_W-1:0] OPCODE_BRANCH = 7'b1100011;

  // control flow class of a returned word
  typedef enum logic [1:0] {
    OP_JAL    = 2'd0,
    OP_BRANCH = 2'd1,
    OP_OTHER  = 2'd2
  } op_class_e;

endpackage

`default_nettype wire

// File: logic/fetch_pc_gen.sv
// Fetch PC generator: picks the next pc and drives request and kill to instruction memory
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,
  input  logic                       redirect_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  input  logic                       mem_ready_i,
  input  logic                       mem_valid_i,
  input  logic                       predict_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] predict_target_i,
  input  logic                       queue_room_i,
  output logic                       mem_req_o,
  output logic [fetch_pkg::XLEN-1:0] mem_addr_o,
  output logic                       mem_kill_o,
  output logic [fetch_pkg::XLEN-1:0] resp_pc_o
);

  // next pc register and its input
  logic [fetch_pkg::XLEN-1:0] npc_d;
  logic [fetch_pkg::XLEN-1:0] npc_q;
  // high in the first cycle after reset, loads the boot address
  logic                       npc_rst_load_q;
  // pc of the request that is currently in flight
  logic [fetch_pkg::XLEN-1:0] resp_pc_q;
  logic                       req_accepted;
  logic                       predict_hit;

  // --------------------------------------------------------------------------
  // memory request side
  // --------------------------------------------------------------------------
  // no request while the boot address is being loaded
  assign mem_req_o    = queue_room_i & ~npc_rst_load_q;
  // word aligned fetch address
  assign mem_addr_o   = {npc_q[fetch_pkg::XLEN-1:fetch_pkg::BOOT_ALIGN_BITS],
                         {fetch_pkg::BOOT_ALIGN_BITS{1'b0}}};
  assign req_accepted = mem_req_o & mem_ready_i;

  // a prediction only counts together with a live response
  assign predict_hit  = mem_valid_i & predict_valid_i;
  // drop whatever gets accepted in a cycle that changes the flow
  assign mem_kill_o   = predict_hit | redirect_valid_i;
  assign resp_pc_o    = resp_pc_q;

  // --------------------------------------------------------------------------
  // next pc select, later assignments win
  // --------------------------------------------------------------------------
  always_comb begin
    // hold by default
    npc_d = npc_q;
    // sequential step once the request is taken
    if (req_accepted) begin
      npc_d = npc_q + fetch_pkg::XLEN'(fetch_pkg::INSTR_BYTES);
    end
    // static prediction from the returned word
    if (predict_hit) begin
      npc_d = predict_target_i;
    end
    // mispredict, exception or trap return from the back end
    if (redirect_valid_i) begin
      npc_d = redirect_pc_i;
    end
    // coming out of reset
    if (npc_rst_load_q) begin
      npc_d = boot_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      npc_rst_load_q <= 1'b1;
      npc_q          <= '0;
    end else begin
      npc_rst_load_q <= 1'b0;
      npc_q          <= npc_d;
    end
  end

  // remember the address so the response can be tagged with it
  always_ff @(posedge clk_i) begin
    if (req_accepted) begin
      resp_pc_q <= mem_addr_o;
    end
  end

endmodule

`default_nettype wire

// File: logic/fetch_predecode.sv
// Fetch predecoder: classifies a returned word and makes the static jump and branch prediction
`timescale 1ns/10ps
`default_nettype none

module fetch_predecode (
  input  logic                       mem_valid_i,
  input  logic [fetch_pkg::ILEN-1:0] mem_data_i,
  input  logic [fetch_pkg::XLEN-1:0] resp_pc_i,
  input  logic                       redirect_valid_i,
  output logic                       predict_valid_o,
  output logic [fetch_pkg::XLEN-1:0] predict_target_o,
  output logic                       push_o,
  output logic [fetch_pkg::XLEN-1:0] push_pc_o,
  output logic [fetch_pkg::ILEN-1:0] push_instr_o,
  output logic                       push_taken_o
);

  fetch_pkg::op_class_e           op_class;
  logic [fetch_pkg::OPCODE_W-1:0] opcode;
  // sign extended immediates of both formats
  logic [fetch_pkg::XLEN-1:0]     j_imm;
  logic [fetch_pkg::XLEN-1:0]     b_imm;
  logic [fetch_pkg::XLEN-1:0]     imm;
  logic                           taken;
  logic                           resp_live;

  // --------------------------------------------------------------------------
  // opcode class
  // --------------------------------------------------------------------------
  assign opcode = mem_data_i[fetch_pkg::OPCODE_W-1:0];

  always_comb begin
    unique case (opcode)
      fetch_pkg::OPCODE_JAL:    op_class = fetch_pkg::OP_JAL;
      fetch_pkg::OPCODE_BRANCH: op_class = fetch_pkg::OP_BRANCH;
      default:                  op_class = fetch_pkg::OP_OTHER;
    endcase
  end

  // --------------------------------------------------------------------------
  // immediates
  // --------------------------------------------------------------------------
  // J-type imm[20|10:1|11|19:12]
  assign j_imm = {{(fetch_pkg::XLEN-21){mem_data_i[31]}}, mem_data_i[31],
                  mem_data_i[19:12], mem_data_i[20], mem_data_i[30:21], 1'b0};
  // B-type imm[12|10:5] and imm[4:1|11]
  assign b_imm = {{(fetch_pkg::XLEN-13){mem_data_i[31]}}, mem_data_i[31],
                  mem_data_i[7], mem_data_i[30:25], mem_data_i[11:8], 1'b0};

  assign imm = (op_class == fetch_pkg::OP_JAL) ? j_imm : b_imm;

  // --------------------------------------------------------------------------
  // static prediction
  // --------------------------------------------------------------------------
  // jal always taken, backward branch taken, forward branch falls through
  assign taken = (op_class == fetch_pkg::OP_JAL) |
                 ((op_class == fetch_pkg::OP_BRANCH) & imm[fetch_pkg::XLEN-1]);

  // a response that meets a redirect belongs to the old path
  assign resp_live = mem_valid_i & ~redirect_valid_i;

  assign predict_valid_o  = resp_live & taken;
  assign predict_target_o = resp_pc_i + imm;

  // queue entry
  assign push_o       = resp_live;
  assign push_pc_o    = resp_pc_i;
  assign push_instr_o = mem_data_i;
  assign push_taken_o = taken;

endmodule

`default_nettype wire

// File: logic/fetch_queue.sv
// Instruction queue: circular buffer between fetch and decode with flush and room level
`timescale 1ns/10ps
`default_nettype none

module fetch_queue (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  logic [fetch_pkg::XLEN-1:0] push_pc_i,
  input  logic [fetch_pkg::ILEN-1:0] push_instr_i,
  input  logic                       push_taken_i,
  input  logic                       fetch_ready_i,
  output logic                       fetch_valid_o,
  output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
  output logic [fetch_pkg::ILEN-1:0] fetch_instr_o,
  output logic                       fetch_taken_o,
  output logic                       room_o
);

  // entry storage
  logic [fetch_pkg::XLEN-1:0]        pc_mem    [fetch_pkg::QUEUE_DEPTH];
  logic [fetch_pkg::ILEN-1:0]        instr_mem [fetch_pkg::QUEUE_DEPTH];
  logic [fetch_pkg::QUEUE_DEPTH-1:0] taken_mem;

  logic [fetch_pkg::QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [fetch_pkg::QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [fetch_pkg::QUEUE_CNT_W-1:0] count_q;
  logic                              pop;

  // --------------------------------------------------------------------------
  // decode side
  // --------------------------------------------------------------------------
  assign fetch_valid_o = (count_q != '0);
  assign fetch_pc_o    = pc_mem[rd_ptr_q];
  assign fetch_instr_o = instr_mem[rd_ptr_q];
  assign fetch_taken_o = taken_mem[rd_ptr_q];
  assign pop           = fetch_valid_o & fetch_ready_i;

  // keep one slot spare for the word that may still be in flight
  assign room_o = (count_q <= fetch_pkg::QUEUE_CNT_W'(fetch_pkg::QUEUE_DEPTH - 2));

  // --------------------------------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // everything queued is on the wrong path
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count unchanged
      if (push_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (!push_i && pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      pc_mem[wr_ptr_q]    <= push_pc_i;
      instr_mem[wr_ptr_q] <= push_instr_i;
      taken_mem[wr_ptr_q] <= push_taken_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/fetch_frontend.sv
// Instruction fetch front end: pc generator, predecoder and queue between memory and decode
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,
  // back end redirect
  input  logic                       redirect_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
  // instruction memory port
  output logic                       mem_req_o,
  output logic [fetch_pkg::XLEN-1:0] mem_addr_o,
  output logic                       mem_kill_o,
  input  logic                       mem_ready_i,
  input  logic                       mem_valid_i,
  input  logic [fetch_pkg::ILEN-1:0] mem_data_i,
  // decode port
  output logic                       fetch_valid_o,
  output logic [fetch_pkg::XLEN-1:0] fetch_pc_o,
  output logic [fetch_pkg::ILEN-1:0] fetch_instr_o,
  output logic                       fetch_taken_o,
  input  logic                       fetch_ready_i
);

  // pc generator to predecoder
  logic [fetch_pkg::XLEN-1:0] resp_pc;
  // predecoder to pc generator
  logic                       predict_valid;
  logic [fetch_pkg::XLEN-1:0] predict_target;
  // predecoder to queue
  logic                       push;
  logic [fetch_pkg::XLEN-1:0] push_pc;
  logic [fetch_pkg::ILEN-1:0] push_instr;
  logic                       push_taken;
  // queue to pc generator
  logic                       queue_room;

  fetch_pc_gen i_pc_gen (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .boot_addr_i      (boot_addr_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .mem_ready_i      (mem_ready_i),
    .mem_valid_i      (mem_valid_i),
    .predict_valid_i  (predict_valid),
    .predict_target_i (predict_target),
    .queue_room_i     (queue_room),
    .mem_req_o        (mem_req_o),
    .mem_addr_o       (mem_addr_o),
    .mem_kill_o       (mem_kill_o),
    .resp_pc_o        (resp_pc)
  );

  fetch_predecode i_predecode (
    .mem_valid_i      (mem_valid_i),
    .mem_data_i       (mem_data_i),
    .resp_pc_i        (resp_pc),
    .redirect_valid_i (redirect_valid_i),
    .predict_valid_o  (predict_valid),
    .predict_target_o (predict_target),
    .push_o           (push),
    .push_pc_o        (push_pc),
    .push_instr_o     (push_instr),
    .push_taken_o     (push_taken)
  );

  // redirect flushes the queue in the same cycle
  fetch_queue i_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (redirect_valid_i),
    .push_i        (push),
    .push_pc_i     (push_pc),
    .push_instr_i  (push_instr),
    .push_taken_i  (push_taken),
    .fetch_ready_i (fetch_ready_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_pc_o    (fetch_pc_o),
    .fetch_instr_o (fetch_instr_o),
    .fetch_taken_o (fetch_taken_o),
    .room_o        (queue_room)
  );

endmodule

`default_nettype wire

// File: verification/fetch_tb_model.svh
// Fetch testbench model: LFSR stimulus source, random program table and static prediction rule
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

  localparam int unsigned PROG_WORDS = 64;
  localparam logic [15:0] LFSR_SEED  = 16'd2632;

  logic [15:0]                lfsr_state;
  // program image indexed by pc bits 7..2, with kind and offset kept beside each word
  logic [fetch_pkg::ILEN-1:0] prog_word [PROG_WORDS];
  fetch_pkg::op_class_e       prog_kind [PROG_WORDS];
  int                         prog_off  [PROG_WORDS];

  // fibonacci lfsr x^16 + x^14 + x^13 + x^11 + 1, one step per returned bit
  function automatic logic [31:0] draw_bits(input int unsigned n);
    logic [31:0] val;
    logic        fb;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  // jal rd, imm per the base isa j-type layout
  function automatic logic [31:0] encode_jal(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // conditional branch, b-type layout
  function automatic logic [31:0] encode_branch(input logic [12:0] imm, input logic [9:0] regs,
                                                input logic [2:0] funct3);
    return {imm[12], imm[10:5], regs, funct3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic build_program();
    int          k;
    int          off;
    logic [2:0]  pick;
    logic [31:0] fields;
    for (k = 0; k < PROG_WORDS; k++) begin
      pick   = 3'(draw_bits(3));
      // small offsets of one to eight words
      off    = (int'(draw_bits(3)) + 1) * 4;
      fields = draw_bits(13);
      case (pick)
        3'd0: begin
          if (draw_bits(1) == 32'd1) begin
            off = -off;
          end
          prog_kind[k] = fetch_pkg::OP_JAL;
          prog_word[k] = encode_jal(21'(off), fields[4:0]);
        end
        3'd1: begin
          prog_kind[k] = fetch_pkg::OP_BRANCH;
          prog_word[k] = encode_branch(13'(off), fields[9:0], fields[12:10]);
        end
        3'd2: begin
          off          = -off;
          prog_kind[k] = fetch_pkg::OP_BRANCH;
          prog_word[k] = encode_branch(13'(off), fields[9:0], fields[12:10]);
        end
        default: begin
          // op-imm with random fields never looks like control flow
          off          = 4;
          prog_kind[k] = fetch_pkg::OP_OTHER;
          prog_word[k] = {25'(draw_bits(25)), 7'b0010011};
        end
      endcase
      prog_off[k] = off;
    end
  endtask

  // jal always taken, branch taken only when it points backwards
  function automatic logic model_taken(input logic [31:0] pc);
    int idx;
    idx = int'(pc[7:2]);
    return (prog_kind[idx] == fetch_pkg::OP_JAL) ||
           ((prog_kind[idx] == fetch_pkg::OP_BRANCH) && (prog_off[idx] < 0));
  endfunction

  function automatic logic [31:0] model_next_pc(input logic [31:0] pc);
    int idx;
    idx = int'(pc[7:2]);
    if (model_taken(pc)) begin
      return pc + 32'(prog_off[idx]);
    end
    return pc + 32'd4;
  endfunction

`endif

// File: verification/fetch_frontend_tb.sv
// Fetch front end testbench: random program, memory responder, decode back-pressure and model checks
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend_tb;

  localparam int unsigned NUM_ENTRIES     = 600;
  // generous bound per decoded entry
  localparam int unsigned WATCHDOG_CYCLES = 40 * NUM_ENTRIES;
  localparam logic [31:0] BOOT_ADDR       = 32'h8000_0000;

  logic                       clk_i;
  logic                       rst_ni;
  logic [fetch_pkg::XLEN-1:0] boot_addr_i;
  logic                       redirect_valid_i;
  logic [fetch_pkg::XLEN-1:0] redirect_pc_i;
  logic                       mem_req_o;
  logic [fetch_pkg::XLEN-1:0] mem_addr_o;
  logic                       mem_kill_o;
  logic                       mem_ready_i;
  logic                       mem_valid_i;
  logic [fetch_pkg::ILEN-1:0] mem_data_i;
  logic                       fetch_valid_o;
  logic [fetch_pkg::XLEN-1:0] fetch_pc_o;
  logic [fetch_pkg::ILEN-1:0] fetch_instr_o;
  logic                       fetch_taken_o;
  logic                       fetch_ready_i;

  `include "fetch_tb_model.svh"

  // expected pc of the next entry decode takes
  logic [31:0] exp_pc;
  logic        redirect_q;
  logic [31:0] rnd;
  int          checked_count;
  int          run_cycles;
  int          mon_cycle;
  int          stall_cnt;

  fetch_frontend dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .boot_addr_i      (boot_addr_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .mem_req_o        (mem_req_o),
    .mem_addr_o       (mem_addr_o),
    .mem_kill_o       (mem_kill_o),
    .mem_ready_i      (mem_ready_i),
    .mem_valid_i      (mem_valid_i),
    .mem_data_i       (mem_data_i),
    .fetch_valid_o    (fetch_valid_o),
    .fetch_pc_o       (fetch_pc_o),
    .fetch_instr_o    (fetch_instr_o),
    .fetch_taken_o    (fetch_taken_o),
    .fetch_ready_i    (fetch_ready_i)
  );

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ---------------------------------------------------------------------------
  // reset, program build and end of run
  // ---------------------------------------------------------------------------
  initial begin
    lfsr_state       = LFSR_SEED;
    rst_ni           = 1'b0;
    boot_addr_i      = BOOT_ADDR;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    mem_ready_i      = 1'b0;
    mem_valid_i      = 1'b0;
    mem_data_i       = '0;
    fetch_ready_i    = 1'b0;
    exp_pc           = BOOT_ADDR;
    redirect_q       = 1'b0;
    rnd              = '0;
    checked_count    = 0;
    run_cycles       = 0;
    mon_cycle        = 0;
    stall_cnt        = 0;
    build_program();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    while (checked_count < NUM_ENTRIES) @(negedge clk_i);
    $display("Test completed successfully");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: only %0d of %0d entries reached decode", checked_count, NUM_ENTRIES);
    $display("Test failed");
    $fatal(1);
  end

  // ---------------------------------------------------------------------------
  // memory responder, decode back-pressure and redirects
  // ---------------------------------------------------------------------------
  always @(posedge clk_i) begin
    // answer one cycle after an accepted request that was not killed
    mem_valid_i <= mem_req_o & mem_ready_i & ~mem_kill_o;
    mem_data_i  <= prog_word[mem_addr_o[7:2]];
    mem_ready_i <= draw_bits(1) == 32'd1;
    if (stall_cnt != 0) begin
      stall_cnt     = stall_cnt - 1;
      fetch_ready_i <= 1'b0;
    end else if (draw_bits(5) == 32'd0) begin
      // long stall so the queue fills and requests stop
      stall_cnt     = 8 + int'(draw_bits(4));
      fetch_ready_i <= 1'b0;
    end else begin
      fetch_ready_i <= draw_bits(2) != 32'd0;
    end
    // keep redirects away from the boot sequence
    if (run_cycles >= 8 && draw_bits(5) == 32'd0) begin
      rnd              = draw_bits(30);
      redirect_valid_i <= 1'b1;
      redirect_pc_i    <= {rnd[29:0], 2'b00};
    end else begin
      redirect_valid_i <= 1'b0;
    end
    if (rst_ni) begin
      run_cycles = run_cycles + 1;
    end
  end

  // ---------------------------------------------------------------------------
  // decode side monitor against the model
  // ---------------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      // quiet while the boot address loads
      if (mon_cycle == 0) begin
        check_value("mem_req_o", 32'(mem_req_o), 32'd0);
        check_value("mem_kill_o", 32'(mem_kill_o), 32'd0);
        check_value("fetch_valid_o", 32'(fetch_valid_o), 32'd0);
      end
      if (mon_cycle == 1) begin
        check_value("mem_req_o", 32'(mem_req_o), 32'd1);
        check_value("mem_addr_o", mem_addr_o, BOOT_ADDR);
      end
      // flushed queue is empty the cycle after a redirect
      if (redirect_q) begin
        check_value("fetch_valid_o", 32'(fetch_valid_o), 32'd0);
      end
      if (redirect_valid_i) begin
        check_value("mem_kill_o", 32'(mem_kill_o), 32'd1);
        exp_pc = redirect_pc_i;
      end else if (fetch_valid_o && fetch_ready_i) begin
        check_value("fetch_pc_o", fetch_pc_o, exp_pc);
        check_value("fetch_instr_o", fetch_instr_o, prog_word[exp_pc[7:2]]);
        check_value("fetch_taken_o", 32'(fetch_taken_o), 32'(model_taken(exp_pc)));
        exp_pc        = model_next_pc(exp_pc);
        checked_count = checked_count + 1;
      end
      redirect_q = redirect_valid_i;
      mon_cycle  = mon_cycle + 1;
    end
  end

endmodule

`default_nettype wire

// File: fetch_frontend.f
+incdir+verification
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/fetch_predecode.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
verification/fetch_frontend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fetch front end simulation with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

verilator --binary --timing -Wno-fatal -f fetch_frontend.f \
  --top-module fetch_frontend_tb -Mdir "$BUILD" -o fetch_frontend_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/fetch_frontend_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
